// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= clint_timer_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# pass or fail comes from the log, not from the simulator status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/axi_lite_req.sv ====
`timescale 1ns/1ps
`include "clint_macros.svh"

module axi_lite_req (
	input  logic             clk,
	input  logic             arst_n,

	// write address and data arrive together
	input  clint_pkg::addr_t awaddr,
	input  logic             awvalid,
	output logic             awready,
	input  clint_pkg::data_t wdata,
	input  logic             wvalid,
	output logic             wready,

	// read address
	input  clint_pkg::addr_t araddr,
	input  logic             arvalid,
	output logic             arready,

	clint_reg_if.bus         regs
);

	logic wr_acc; // write handshake this cycle
	logic rd_acc; // read handshake this cycle

	// full address compare against the map
	function automatic clint_pkg::reg_sel_t decode(input clint_pkg::addr_t a);
		clint_pkg::reg_sel_t sel;
		case (a)
			clint_pkg::addr_t'(`CLINT_BASE + `CLINT_MTIME_OFS):    sel = clint_pkg::SEL_MTIME;
			clint_pkg::addr_t'(`CLINT_BASE + `CLINT_MTIMECMP_OFS): sel = clint_pkg::SEL_MTIMECMP;
			default:                                               sel = clint_pkg::SEL_NONE;
		endcase
		return sel;
	endfunction

	// aw and w go together and wait until b is taken
	assign wr_acc = awvalid & wvalid & ~regs.wr_busy;
	assign rd_acc = arvalid & ~regs.rd_busy; // one read outstanding

	assign awready = wr_acc; // both readies follow the joint accept
	assign wready  = wr_acc;
	assign arready = rd_acc;

	// strobes are the handshakes themselves
	assign regs.wr_stb = wr_acc;
	assign regs.rd_stb = rd_acc;

	assign regs.wr_sel = decode(awaddr); // meaningful only with wr_stb
	assign regs.rd_sel = decode(araddr);
	assign regs.wdata  = wdata;          // passed straight through

	// resp side must raise busy right after a strobe
	// so the same channel cannot strobe twice in a row
	a_wr_single: assert property (
		@(posedge clk) disable iff (!arst_n)
		regs.wr_stb |=> !regs.wr_stb
	) else $error("back-to-back write strobes");

	a_rd_single: assert property (
		@(posedge clk) disable iff (!arst_n)
		regs.rd_stb |=> !regs.rd_stb
	) else $error("back-to-back read strobes");

	// busy has to show up one cycle after the accept
	a_wr_busy_follows: assert property (
		@(posedge clk) disable iff (!arst_n)
		regs.wr_stb |=> regs.wr_busy
	) else $error("b not held after write");

	a_rd_busy_follows: assert property (
		@(posedge clk) disable iff (!arst_n)
		regs.rd_stb |=> regs.rd_busy
	) else $error("r not held after read");

endmodule

// ==== src/axi_lite_resp.sv ====
`timescale 1ns/1ps
`include "clint_macros.svh"

module axi_lite_resp (
	input  logic             clk,
	input  logic             arst_n,

	// write response
	output logic             bvalid,
	input  logic             bready,
	output clint_pkg::resp_t bresp,

	// read data
	output logic             rvalid,
	input  logic             rready,
	output clint_pkg::data_t rdata,
	output clint_pkg::resp_t rresp,

	clint_reg_if.rsp         regs
);

	clint_pkg::rd_state_t rd_state;

	// r channel holder
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_state <= clint_pkg::RD_IDLE;
		end else begin
			case (rd_state)
				clint_pkg::RD_IDLE: if (regs.rd_stb) rd_state <= clint_pkg::RD_HOLD;
				clint_pkg::RD_HOLD: if (rready)      rd_state <= clint_pkg::RD_IDLE;
				default:                             rd_state <= clint_pkg::RD_IDLE;
			endcase
		end
	end

	// r payload, sampled in the accept cycle
	always_ff @(posedge clk) begin
		if (regs.rd_stb) begin
			rdata <= regs.rdata; // already zero when unmapped
			rresp <= (regs.rd_sel == clint_pkg::SEL_NONE) ? `CLINT_RESP_DECERR : `CLINT_RESP_OKAY;
		end
	end

	assign rvalid = (rd_state == clint_pkg::RD_HOLD);

	// b channel, a flag is enough
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bvalid <= 1'b0;
		end else if (regs.wr_stb) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0; // handshake done
		end
	end

	always_ff @(posedge clk) begin
		if (regs.wr_stb) begin
			bresp <= (regs.wr_sel == clint_pkg::SEL_NONE) ? `CLINT_RESP_DECERR : `CLINT_RESP_OKAY;
		end
	end

	assign regs.wr_busy = bvalid; // stalls aw/w acceptance
	assign regs.rd_busy = rvalid; // stalls ar acceptance

	// responses wait for their ready, payload frozen meanwhile
	a_b_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp)
	) else $error("bvalid dropped without bready");

	a_r_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
	) else $error("r channel changed while held");

endmodule

// ==== src/clint_macros.svh ====
`ifndef CLINT_MACROS_SVH
`define CLINT_MACROS_SVH

// bus widths
`define CLINT_ADDR_W 32
`define CLINT_DATA_W 64 // full 64-bit beats only

// memory map for a single hart
`define CLINT_BASE         32'h0200_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000 // hart 0 compare slot
`define CLINT_MTIME_OFS    32'h0000_BFF8

// axi response codes
`define CLINT_RESP_OKAY   2'b00
`define CLINT_RESP_DECERR 2'b11

`define CLINT_MTIMECMP_RST 64'hFFFF_FFFF_FFFF_FFFF // irq held off until software sets it

`endif

// ==== src/clint_pkg.sv ====
`include "clint_macros.svh"

package clint_pkg;

	typedef logic [`CLINT_ADDR_W-1:0] addr_t; // byte address on the bus
	typedef logic [`CLINT_DATA_W-1:0] data_t; // register width and beat width
	typedef logic [1:0]               resp_t; // bresp / rresp encoding

	// which register an access lands on
	typedef enum logic [1:0] {
		SEL_NONE,     // unmapped
		SEL_MTIME,
		SEL_MTIMECMP
	} reg_sel_t;

	// read response holding
	typedef enum logic {
		RD_IDLE,
		RD_HOLD
	} rd_state_t;

endpackage

// ==== src/clint_reg_if.sv ====
`timescale 1ns/1ps
`include "clint_macros.svh"

interface clint_reg_if;

	logic                wr_stb;  // one cycle per accepted write
	clint_pkg::reg_sel_t wr_sel;
	clint_pkg::data_t    wdata;
	logic                rd_stb;  // one cycle per accepted read
	clint_pkg::reg_sel_t rd_sel;
	clint_pkg::data_t    rdata;   // comb, follows rd_sel
	logic                wr_busy; // b still held
	logic                rd_busy; // r still held

	// request decode side
	modport bus (output wr_stb, wr_sel, wdata, rd_stb, rd_sel, input wr_busy, rd_busy);

	// timer registers
	modport core (input wr_stb, wr_sel, wdata, rd_stb, rd_sel, output rdata);

	// response holding side
	modport rsp (input wr_stb, wr_sel, rd_stb, rd_sel, rdata, output wr_busy, rd_busy);

endinterface

// ==== src/clint_timer.sv ====
`timescale 1ns/1ps
`include "clint_macros.svh"

module clint_timer (
	input  logic             clk,
	input  logic             arst_n,

	// aw + w, presented together
	input  clint_pkg::addr_t awaddr,
	input  logic             awvalid,
	output logic             awready,
	input  clint_pkg::data_t wdata,
	input  logic             wvalid,
	output logic             wready,

	// b
	output logic             bvalid,
	input  logic             bready,
	output clint_pkg::resp_t bresp,

	// ar
	input  clint_pkg::addr_t araddr,
	input  logic             arvalid,
	output logic             arready,

	// r
	output logic             rvalid,
	input  logic             rready,
	output clint_pkg::data_t rdata,
	output clint_pkg::resp_t rresp,

	// timer state, visible for debug
	output clint_pkg::data_t mtime,
	output clint_pkg::data_t mtimecmp,
	output logic             timer_irq // to hart 0 mtip
);

	clint_reg_if regs_if ();

	axi_lite_req u_req (
		.clk     (clk),
		.arst_n  (arst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.regs    (regs_if.bus)
	);

	mtimer_core u_core (
		.clk       (clk),
		.arst_n    (arst_n),
		.mtime     (mtime),
		.mtimecmp  (mtimecmp),
		.timer_irq (timer_irq),
		.regs      (regs_if.core)
	);

	axi_lite_resp u_resp (
		.clk    (clk),
		.arst_n (arst_n),
		.bvalid (bvalid),
		.bready (bready),
		.bresp  (bresp),
		.rvalid (rvalid),
		.rready (rready),
		.rdata  (rdata),
		.rresp  (rresp),
		.regs   (regs_if.rsp)
	);

endmodule

// ==== src/mtimer_core.sv ====
`timescale 1ns/1ps
`include "clint_macros.svh"

module mtimer_core (
	input  logic             clk,
	input  logic             arst_n,
	output clint_pkg::data_t mtime,
	output clint_pkg::data_t mtimecmp,
	output logic             timer_irq, // registered compare
	clint_reg_if.core        regs
);

	logic wr_mtime;    // software load of the counter
	logic wr_mtimecmp;

	assign wr_mtime    = regs.wr_stb && (regs.wr_sel == clint_pkg::SEL_MTIME);
	assign wr_mtimecmp = regs.wr_stb && (regs.wr_sel == clint_pkg::SEL_MTIMECMP);

	// free-running counter, a write wins over the increment
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mtime <= '0;
		end else if (wr_mtime) begin
			mtime <= regs.wdata;
		end else begin
			mtime <= mtime + clint_pkg::data_t'(1); // wraps at 2^64
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mtimecmp <= `CLINT_MTIMECMP_RST;
		end else if (wr_mtimecmp) begin
			mtimecmp <= regs.wdata;
		end
	end

	// irq one cycle behind the compare
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp); // unsigned
		end
	end

	// read mux, unmapped reads as zero
	always_comb begin
		case (regs.rd_sel)
			clint_pkg::SEL_MTIME:    regs.rdata = mtime;
			clint_pkg::SEL_MTIMECMP: regs.rdata = mtimecmp;
			default:                 regs.rdata = '0;
		endcase
	end

	a_mtime_step: assert property (
		@(posedge clk) disable iff (!arst_n)
		!wr_mtime |=> (mtime == clint_pkg::data_t'($past(mtime) + 1))
	) else $error("mtime did not advance by one");

endmodule

// ==== tb.f ====
+incdir+src
src/clint_pkg.sv
src/clint_reg_if.sv
src/axi_lite_req.sv
src/mtimer_core.sv
src/axi_lite_resp.sv
src/clint_timer.sv
verification/tb_clk_gen.sv
verification/clint_timer_checker.sv
verification/clint_timer_tb.sv

// ==== verification/clint_timer_checker.sv ====
`timescale 1ns/1ps
`include "clint_macros.svh"

module clint_timer_checker (
	input  logic             clk,
	input  logic             arst_n,
	input  clint_pkg::addr_t awaddr,
	input  logic             awvalid,
	input  logic             awready,
	input  clint_pkg::data_t wdata,
	input  logic             wvalid,
	input  logic             wready,
	input  logic             bvalid,
	input  logic             bready,
	input  clint_pkg::resp_t bresp,
	input  clint_pkg::addr_t araddr,
	input  logic             arvalid,
	input  logic             arready,
	input  logic             rvalid,
	input  logic             rready,
	input  clint_pkg::data_t rdata,
	input  clint_pkg::resp_t rresp,
	input  clint_pkg::data_t mtime,
	input  clint_pkg::data_t mtimecmp,
	input  logic             timer_irq,
	input  logic [127:0]     test_name, // ascii name zero padded on the left
	input  clint_pkg::resp_t exp_resp,
	output int               done_cnt,
	output int               fail_cnt,
	output int               err_cnt
);

	localparam clint_pkg::addr_t MTIME_A = `CLINT_BASE + `CLINT_MTIME_OFS;
	localparam clint_pkg::addr_t CMP_A   = `CLINT_BASE + `CLINT_MTIMECMP_OFS;

	clint_pkg::data_t m_mtime;    // reference counter
	clint_pkg::data_t m_cmp;      // reference compare value
	logic             m_irq;      // compare result one cycle late
	clint_pkg::data_t exp_rdata;  // model value at the ar accept
	logic             b_held;     // b was up without bready last edge
	logic             r_held;
	clint_pkg::resp_t held_bresp;
	clint_pkg::resp_t held_rresp;
	clint_pkg::data_t held_rdata;
	int               err_mark;   // err_cnt when the running test began

	function automatic string name_of(input logic [127:0] v);
		string s;
		s = "";
		for (int i = 15; i >= 0; i--) begin
			if (v[i*8 +: 8] != 8'h00) s = $sformatf("%s%c", s, v[i*8 +: 8]);
		end
		return s;
	endfunction

	task automatic value_err(input string what, input clint_pkg::data_t exp,
	                         input clint_pkg::data_t act);
		$display("FAILED %s: %s expected %h actual %h", name_of(test_name), what, exp, act);
		err_cnt++;
	endtask

	task automatic rule_err(input string what);
		$display("ERROR in %s: %s", name_of(test_name), what);
		err_cnt++;
	endtask

	// one line per finished test
	task automatic close_test();
		done_cnt++;
		if (err_cnt != err_mark) begin
			fail_cnt++;
			$display("test %0d %s: failed, %0d errors", done_cnt, name_of(test_name),
			         err_cnt - err_mark);
		end else begin
			$display("test %0d %s: ok", done_cnt, name_of(test_name));
		end
		err_mark = err_cnt;
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			m_mtime    <= '0;
			m_cmp      <= `CLINT_MTIMECMP_RST;
			m_irq      <= 1'b0;
			exp_rdata  <= '0;
			b_held     <= 1'b0;
			r_held     <= 1'b0;
			held_bresp <= '0;
			held_rresp <= '0;
			held_rdata <= '0;
			done_cnt = 0;
			fail_cnt = 0;
			err_cnt  = 0;
			err_mark = 0;
		end else begin
			// timer ports against the model every cycle
			if (mtime !== m_mtime) value_err("mtime", m_mtime, mtime);
			if (mtimecmp !== m_cmp) value_err("mtimecmp", m_cmp, mtimecmp);
			if (timer_irq !== m_irq) begin
				value_err("timer_irq", clint_pkg::data_t'(m_irq), clint_pkg::data_t'(timer_irq));
			end

			// aw and w are taken in the same cycle
			if (awready !== wready) rule_err("awready and wready disagree");

			// stalls while a response is held
			if (bvalid && awvalid && awready) rule_err("write accepted while B response held");
			if (rvalid && arvalid && arready) rule_err("read accepted while R response held");
			if (b_held && !(bvalid && bresp === held_bresp)) begin
				rule_err("B response dropped or changed before bready");
			end
			if (r_held && !(rvalid && rdata === held_rdata && rresp === held_rresp)) begin
				rule_err("R response dropped or changed before rready");
			end
			b_held     <= bvalid && !bready;
			r_held     <= rvalid && !rready;
			held_bresp <= bresp;
			held_rresp <= rresp;
			held_rdata <= rdata;

			// register model
			m_irq <= (m_mtime >= m_cmp);
			if (awvalid && wvalid && awready && wready && awaddr == MTIME_A) begin
				m_mtime <= wdata; // load wins
			end else begin
				m_mtime <= m_mtime + 64'd1;
			end
			if (awvalid && wvalid && awready && wready && awaddr == CMP_A) m_cmp <= wdata;
			if (arvalid && arready) begin
				exp_rdata <= (araddr == MTIME_A) ? m_mtime :
				             (araddr == CMP_A)   ? m_cmp   : '0; // holes read zero
			end

			// response handshakes end a test
			if (bvalid && bready) begin
				if (bresp !== exp_resp) begin
					value_err("bresp", clint_pkg::data_t'(exp_resp), clint_pkg::data_t'(bresp));
				end
				close_test();
			end
			if (rvalid && rready) begin
				if (rresp !== exp_resp) begin
					value_err("rresp", clint_pkg::data_t'(exp_resp), clint_pkg::data_t'(rresp));
				end
				if (rdata !== exp_rdata) value_err("rdata", exp_rdata, rdata);
				close_test();
			end
		end
	end

endmodule

// ==== verification/clint_timer_tb.sv ====
`timescale 1ns/1ps
`include "clint_macros.svh"

module clint_timer_tb;

	localparam int NUM_TESTS      = 12;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * 12 + 20; // longest entry is about 10 cycles
	localparam clint_pkg::addr_t MTIME_A = `CLINT_BASE + `CLINT_MTIME_OFS;
	localparam clint_pkg::addr_t CMP_A   = `CLINT_BASE + `CLINT_MTIMECMP_OFS;
	localparam clint_pkg::addr_t HOLE_A  = `CLINT_BASE + 32'h0000_0008; // unmapped slot in clint

	logic             clk;
	logic             arst_n;
	clint_pkg::addr_t awaddr;
	logic             awvalid;
	logic             awready;
	clint_pkg::data_t wdata;
	logic             wvalid;
	logic             wready;
	logic             bvalid;
	logic             bready;
	clint_pkg::resp_t bresp;
	clint_pkg::addr_t araddr;
	logic             arvalid;
	logic             arready;
	logic             rvalid;
	logic             rready;
	clint_pkg::data_t rdata;
	clint_pkg::resp_t rresp;
	clint_pkg::data_t mtime;
	clint_pkg::data_t mtimecmp;
	logic             timer_irq;

	logic [127:0]     cur_name;
	clint_pkg::resp_t cur_resp;
	int               done_cnt;
	int               fail_cnt;
	int               err_cnt;
	int               seed      = 32'h30a143f5;
	int               cycles    = 0;
	logic             reset_bad = 1'b0;

	// stimulus table with one column per field
	string            t_name  [NUM_TESTS];
	logic             t_wr    [NUM_TESTS];
	clint_pkg::addr_t t_addr  [NUM_TESTS];
	clint_pkg::data_t t_data  [NUM_TESTS];
	clint_pkg::resp_t t_resp  [NUM_TESTS];
	int               t_delay [NUM_TESTS]; // ready delay where -1 draws 0..7
	int               n_loaded = 0;

	tb_clk_gen u_clk (.clk(clk), .arst_n(arst_n));

	clint_timer dut0 (
		.clk(clk), .arst_n(arst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.mtime(mtime), .mtimecmp(mtimecmp), .timer_irq(timer_irq)
	);

	clint_timer_checker u_checker (
		.clk(clk), .arst_n(arst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
		.wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.mtime(mtime), .mtimecmp(mtimecmp), .timer_irq(timer_irq),
		.test_name(cur_name), .exp_resp(cur_resp),
		.done_cnt(done_cnt), .fail_cnt(fail_cnt), .err_cnt(err_cnt)
	);

	task automatic add_entry(input string n, input logic w, input clint_pkg::addr_t a,
	                         input clint_pkg::data_t d, input clint_pkg::resp_t r, input int dl);
		t_name[n_loaded]  = n;
		t_wr[n_loaded]    = w;
		t_addr[n_loaded]  = a;
		t_data[n_loaded]  = d;
		t_resp[n_loaded]  = r;
		t_delay[n_loaded] = dl;
		n_loaded++;
	endtask

	function automatic logic [127:0] pack_name(input string s);
		logic [127:0] v;
		v = '0;
		for (int k = 0; k < s.len() && k < 16; k++) begin
			v = {v[119:0], s[k]};
		end
		return v;
	endfunction

	// one request and its response with ready held back
	task automatic apply_entry(input int idx);
		int delay;
		delay = (t_delay[idx] < 0) ? ($unsigned($random(seed)) % 8) : t_delay[idx];
		cur_name = pack_name(t_name[idx]);
		cur_resp = t_resp[idx];
		if (t_wr[idx]) begin
			awaddr  = t_addr[idx];
			wdata   = t_data[idx];
			awvalid = 1'b1;
			wvalid  = 1'b1;
			do @(posedge clk); while (!(awready && wready));
		end else begin
			araddr  = t_addr[idx];
			arvalid = 1'b1;
			do @(posedge clk); while (!arready);
		end
		#1; // valid stays up to probe the stall while the response waits
		repeat (delay) begin
			@(posedge clk);
			#1;
		end
		bready = t_wr[idx];
		rready = !t_wr[idx];
		do @(posedge clk); while (!(t_wr[idx] ? bvalid : rvalid));
		#1;
		bready  = 1'b0;
		rready  = 1'b0;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		arvalid = 1'b0;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: no finish after %0d cycles, a handshake never came", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		cur_name = '0;
		cur_resp = `CLINT_RESP_OKAY;

		add_entry("rst_cmp_rd",   1'b0, CMP_A,   '0, `CLINT_RESP_OKAY, 0);
		add_entry("mtime_wr",     1'b1, MTIME_A, 64'h0000_0001_0000_0100, `CLINT_RESP_OKAY, 1);
		add_entry("mtime_rd",     1'b0, MTIME_A, '0, `CLINT_RESP_OKAY, 0);
		add_entry("cmp_wr_low",   1'b1, CMP_A,   64'h0000_0001_0000_0000, `CLINT_RESP_OKAY, 0);
		add_entry("cmp_rd_low",   1'b0, CMP_A,   '0, `CLINT_RESP_OKAY, -1);
		add_entry("cmp_wr_high",  1'b1, CMP_A,   64'h0000_0007_0000_0000, `CLINT_RESP_OKAY, -1);
		add_entry("cmp_rd_high",  1'b0, CMP_A,   '0, `CLINT_RESP_OKAY, -1);
		add_entry("hole_wr",      1'b1, HOLE_A,  64'hDEAD_BEEF_0000_0001, `CLINT_RESP_DECERR, -1);
		add_entry("hole_rd",      1'b0, HOLE_A,  '0, `CLINT_RESP_DECERR, -1);
		add_entry("far_rd",       1'b0, 32'h0000_0000, '0, `CLINT_RESP_DECERR, -1);
		add_entry("mtime_wr_top", 1'b1, MTIME_A, 64'hFFFF_FFFF_FFFF_FFF0, `CLINT_RESP_OKAY, -1);
		add_entry("mtime_rd_top", 1'b0, MTIME_A, '0, `CLINT_RESP_OKAY, -1); // wraps soon after

		wait (arst_n);
		@(posedge clk);
		#1;
		if (bvalid || rvalid || timer_irq || awready || wready || arready) begin
			$display("outputs not idle after reset");
			reset_bad = 1'b1;
		end

		for (int i = 0; i < NUM_TESTS; i++) begin
			apply_entry(i);
		end

		repeat (2) @(posedge clk);
		#1;
		$display("done: %0d of %0d tests, %0d failed, %0d errors",
		         done_cnt, NUM_TESTS, fail_cnt, err_cnt);
		if (!reset_bad && err_cnt == 0 && fail_cnt == 0 && done_cnt == NUM_TESTS) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	// 100 MHz
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk); // two full cycles in reset
		#1 arst_n = 1'b1;          // release away from the edge
	end

endmodule
